/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = mpfReadTop_tb
FILELIST  = compile.f
OBJDIR    = obj_dir

.PHONY: simulate clean

# The run passes only when the pass line shows up in the output
simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | awk '{ print } /^ALL TESTS PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJDIR)

/* compile.f */
+incdir+include
hw/mpf_pkg.sv
hw/readScoreboard.sv
hw/sortReadRsp.sv
hw/memResponder.sv
hw/mpfReadTop.sv
testbench/mpfReadTop_tb.sv

/* hw/memResponder.sv */
// Out-of-order platform memory stub
`timescale 1ns/1ps
`include "mpf_settings.svh"

module memResponder
    import mpf_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  c0Req_t c0Req,
    input  c1Req_t c1Req,
    output c0Rsp_t c0Rsp,
    output logic   c0AlmFull,
    output logic   c1AlmFull
);

    localparam int Depth    = `MPF_STACK_DEPTH;
    localparam int Words    = 2 ** `MPF_ADDR_WIDTH;
    localparam int CntWidth = $clog2(Depth + 1);
    localparam int PtrWidth = $clog2(Depth);

    data_t mem [Words];

    // Pending reads, newest on top
    addr_t  stackAddr  [Depth];
    mdata_t stackMdata [Depth];
    logic [CntWidth-1:0] stackCount;
    logic [PtrWidth-1:0] topIdx;
    logic [PtrWidth-1:0] pushIdx;

    logic popToggle;
    logic pushEn;
    logic popEn;

    // Write ack staged for one cycle before it leaves
    logic   ackDue;
    mdata_t ackMdata;

    logic   rspRdValid;
    logic   rspWrValid;
    mdata_t rspMdata;
    data_t  rspData;

    assign pushEn = c0Req.rdValid;

    // Pop every other cycle and step aside for a due write ack
    assign popEn  = popToggle && (stackCount != '0) && !ackDue;
    assign topIdx = PtrWidth'(stackCount - CntWidth'(1));

    // A push during a pop takes over the slot that is being freed
    assign pushIdx = popEn ? topIdx : PtrWidth'(stackCount);

    // ================================================
    // Control state
    // ================================================

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            stackCount <= '0;
            popToggle  <= 1'b0;
            ackDue     <= 1'b0;
            rspRdValid <= 1'b0;
            rspWrValid <= 1'b0;
        end
        else
        begin
            popToggle  <= !popToggle;
            ackDue     <= c1Req.wrValid;
            rspRdValid <= popEn;
            rspWrValid <= ackDue;

            if (pushEn && !popEn)
            begin
                stackCount <= stackCount + CntWidth'(1);
            end
            else if (popEn && !pushEn)
            begin
                stackCount <= stackCount - CntWidth'(1);
            end
        end
    end

    // ================================================
    // Memory, stack and response payload
    // ================================================

    always_ff @(posedge clk)
    begin
        if (c1Req.wrValid)
        begin
            mem[c1Req.addr] <= c1Req.data;
        end

        if (pushEn)
        begin
            stackAddr[pushIdx]  <= c0Req.addr;
            stackMdata[pushIdx] <= c0Req.mdata;
        end

        ackMdata <= c1Req.mdata;

        // The read sees the memory as it was before this edge's write
        if (popEn)
        begin
            rspMdata <= stackMdata[topIdx];
            rspData  <= mem[stackAddr[topIdx]];
        end
        else
        begin
            rspMdata <= ackMdata;
            rspData  <= '0;
        end
    end

    assign c0Rsp = '{rdValid: rspRdValid, wrValid: rspWrValid,
                     mdata: rspMdata, data: rspData};

    // Writes also slow down while the stack drains
    assign c0AlmFull = stackCount >= CntWidth'(Depth - `MPF_STACK_RESERVE);
    assign c1AlmFull = c0AlmFull;

    pushIntoFull: assert property (@(posedge clk) disable iff (rst)
        pushEn |-> popEn || (stackCount < CntWidth'(Depth)))
        else $error("Read pushed into a full pending stack");

endmodule

/* hw/mpfReadTop.sv */
// Sorted read subsystem top
`timescale 1ns/1ps

module mpfReadTop
    import mpf_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  c0Req_t c0Req,
    input  c1Req_t c1Req,
    output c0Rsp_t c0Rsp,
    output logic   c0AlmFull,
    output logic   c1AlmFull
);

    // Links between the sorter and the platform stub
    c0Req_t platC0Req;
    c1Req_t platC1Req;
    c0Rsp_t platC0Rsp;
    logic   platC0AlmFull;
    logic   platC1AlmFull;

    // Channels stay in sync so reads and writes keep their relative order
    sortReadRsp #(
        .SyncReqChannels (1)
    ) i_sortReadRsp (
        .clk           (clk),
        .rst           (rst),
        .afuC0Req      (c0Req),
        .afuC1Req      (c1Req),
        .afuC0Rsp      (c0Rsp),
        .afuC0AlmFull  (c0AlmFull),
        .afuC1AlmFull  (c1AlmFull),
        .platC0Req     (platC0Req),
        .platC1Req     (platC1Req),
        .platC0Rsp     (platC0Rsp),
        .platC0AlmFull (platC0AlmFull),
        .platC1AlmFull (platC1AlmFull)
    );

    memResponder i_memResponder (
        .clk       (clk),
        .rst       (rst),
        .c0Req     (platC0Req),
        .c1Req     (platC1Req),
        .c0Rsp     (platC0Rsp),
        .c0AlmFull (platC0AlmFull),
        .c1AlmFull (platC1AlmFull)
    );

endmodule

/* hw/mpf_pkg.sv */
// Memory request subsystem types
`include "mpf_settings.svh"

package mpf_pkg;

    // ================================================
    // Basic fields
    // ================================================

    // Metadata tag, returned unchanged with the response
    typedef logic [`MPF_MDATA_WIDTH-1:0] mdata_t;

    // Word address
    typedef logic [`MPF_ADDR_WIDTH-1:0] addr_t;

    // One data word
    typedef logic [`MPF_DATA_WIDTH-1:0] data_t;

    // ================================================
    // Channel payloads
    // ================================================

    // Channel 0 request, reads only
    typedef struct packed {
        logic   rdValid;
        addr_t  addr;
        mdata_t mdata;
    } c0Req_t;

    // Channel 1 request, writes carry their data alongside
    typedef struct packed {
        logic   wrValid;
        addr_t  addr;
        mdata_t mdata;
        data_t  data;
    } c1Req_t;

    // Channel 0 response carries both read data and write acknowledgements
    typedef struct packed {
        logic   rdValid;
        logic   wrValid;
        mdata_t mdata;
        data_t  data;
    } c0Rsp_t;

endpackage

/* hw/readScoreboard.sv */
// In-order read scoreboard
`timescale 1ns/1ps
`include "mpf_settings.svh"

module readScoreboard
    import mpf_pkg::*;
#(
    localparam int IdxWidth = $clog2(`MPF_SB_ENTRIES)
)
(
    input  logic                clk,
    input  logic                rst,

    // Slot allocation, one per read request
    input  logic                enqEn,
    input  mdata_t              enqMeta,
    output logic                notFull,
    output logic [IdxWidth-1:0] enqIdx,

    // Response data, arriving in any order
    input  logic                enqDataEn,
    input  logic [IdxWidth-1:0] enqDataIdx,
    input  data_t               enqData,

    // In-order retirement of the head slot
    input  logic                deqEn,
    output logic                notEmpty,
    output data_t               first,
    output mdata_t              firstMeta
);

    localparam int Entries  = `MPF_SB_ENTRIES;
    localparam int CntWidth = $clog2(Entries + 1);

    typedef logic [IdxWidth-1:0] idx_t;

    // Head is the oldest allocated slot and tail the next one to hand out
    idx_t headPtr;
    idx_t tailPtr;
    logic [CntWidth-1:0] freeCount;

    // Busy marks an allocated slot, ready marks one whose data has returned
    logic [Entries-1:0] busy;
    logic [Entries-1:0] ready;

    data_t  dataMem [Entries];
    mdata_t metaMem [Entries];

    // Pointer advance with wrap, written out so any slot count works
    function automatic idx_t nextIdx(input idx_t idx);
        nextIdx = (idx == idx_t'(Entries - 1)) ? '0 : idx + idx_t'(1);
    endfunction

    // Keep a few slots back so reads already in flight still find room
    assign notFull   = freeCount > CntWidth'(`MPF_SB_RESERVE);
    assign enqIdx    = tailPtr;
    assign notEmpty  = busy[headPtr] && ready[headPtr];
    assign first     = dataMem[headPtr];
    assign firstMeta = metaMem[headPtr];

    // ================================================
    // Slot state
    // ================================================

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            headPtr   <= '0;
            tailPtr   <= '0;
            freeCount <= CntWidth'(Entries);
            busy      <= '0;
            ready     <= '0;
        end
        else
        begin
            // Head and tail only meet when all slots are free or all busy,
            // so retire and allocate never touch the same slot
            if (deqEn)
            begin
                busy[headPtr]  <= 1'b0;
                ready[headPtr] <= 1'b0;
                headPtr        <= nextIdx(headPtr);
            end

            if (enqEn)
            begin
                busy[tailPtr] <= 1'b1;
                tailPtr       <= nextIdx(tailPtr);
            end

            if (enqDataEn)
            begin
                ready[enqDataIdx] <= 1'b1;
            end

            if (enqEn && !deqEn)
            begin
                freeCount <= freeCount - CntWidth'(1);
            end
            else if (deqEn && !enqEn)
            begin
                freeCount <= freeCount + CntWidth'(1);
            end
        end
    end

    // Tags and data hold payload only
    always_ff @(posedge clk)
    begin
        if (enqEn)
        begin
            metaMem[tailPtr] <= enqMeta;
        end
        if (enqDataEn)
        begin
            dataMem[enqDataIdx] <= enqData;
        end
    end

    // ================================================
    // Protocol checks
    // ================================================

    enqNoFreeSlot: assert property (@(posedge clk) disable iff (rst)
        enqEn |-> freeCount != '0)
        else $error("Scoreboard enqueue with no free slot");

    dataToFreeSlot: assert property (@(posedge clk) disable iff (rst)
        enqDataEn |-> busy[enqDataIdx])
        else $error("Scoreboard data written to an unallocated slot");

    deqNotReady: assert property (@(posedge clk) disable iff (rst)
        deqEn |-> notEmpty)
        else $error("Scoreboard dequeue while head has no data");

endmodule

/* hw/sortReadRsp.sv */
// Read response sorter shim
`timescale 1ns/1ps
`include "mpf_settings.svh"

module sortReadRsp
    import mpf_pkg::*;
#(
    // Nonzero ties both almost-full outputs together to keep load/store order
    parameter int SyncReqChannels = 1
)
(
    input  logic   clk,
    input  logic   rst,

    // User side
    input  c0Req_t afuC0Req,
    input  c1Req_t afuC1Req,
    output c0Rsp_t afuC0Rsp,
    output logic   afuC0AlmFull,
    output logic   afuC1AlmFull,

    // Platform side
    output c0Req_t platC0Req,
    output c1Req_t platC1Req,
    input  c0Rsp_t platC0Rsp,
    input  logic   platC0AlmFull,
    input  logic   platC1AlmFull
);

    localparam int IdxWidth = $clog2(`MPF_SB_ENTRIES);

    typedef logic [IdxWidth-1:0] idx_t;

    logic   sbNotFull;
    idx_t   sbEnqIdx;
    logic   sbNotEmpty;
    data_t  sbFirst;
    mdata_t sbFirstMeta;
    logic   c0AlmFull;
    logic   c1AlmFull;
    logic   rspRdValid;

    // ================================================
    // Almost-full merging
    // ================================================

    // The scoreboard reserve already covers in-flight reads, no other buffer
    assign c0AlmFull = platC0AlmFull || !sbNotFull;
    assign c1AlmFull = platC1AlmFull;

    generate
        if (SyncReqChannels == 0)
        begin : gNoSync
            assign afuC0AlmFull = c0AlmFull;
            assign afuC1AlmFull = c1AlmFull;
        end
        else
        begin : gSync
            assign afuC0AlmFull = c0AlmFull || c1AlmFull;
            assign afuC1AlmFull = c0AlmFull || c1AlmFull;
        end
    endgenerate

    // ================================================
    // Channel 0 reads and sorted responses
    // ================================================

    // Platform tags come back as slot indices
    readScoreboard i_readScoreboard (
        .clk        (clk),
        .rst        (rst),
        .enqEn      (afuC0Req.rdValid),
        .enqMeta    (afuC0Req.mdata),
        .notFull    (sbNotFull),
        .enqIdx     (sbEnqIdx),
        .enqDataEn  (platC0Rsp.rdValid),
        .enqDataIdx (idx_t'(platC0Rsp.mdata)),
        .enqData    (platC0Rsp.data),
        .deqEn      (rspRdValid),
        .notEmpty   (sbNotEmpty),
        .first      (sbFirst),
        .firstMeta  (sbFirstMeta)
    );

    // The original tag waits in the scoreboard until the data returns
    assign platC0Req.rdValid = afuC0Req.rdValid;
    assign platC0Req.addr    = afuC0Req.addr;
    assign platC0Req.mdata   = mdata_t'(sbEnqIdx);

    // Write acks are unbuffered, so the sorted head waits for a free cycle
    assign rspRdValid = sbNotEmpty && !platC0Rsp.wrValid;

    assign afuC0Rsp.rdValid = rspRdValid;
    assign afuC0Rsp.wrValid = platC0Rsp.wrValid;
    assign afuC0Rsp.mdata   = rspRdValid ? sbFirstMeta : platC0Rsp.mdata;
    assign afuC0Rsp.data    = rspRdValid ? sbFirst : platC0Rsp.data;

    // ================================================
    // Channel 1 writes pass straight through
    // ================================================

    assign platC1Req = afuC1Req;

    // Reserve slots must hold everything the AFU sends once it sees almost-full
    enqUnderAlmFull: assert property (@(posedge clk) disable iff (rst)
        afuC0Req.rdValid |-> !afuC0AlmFull)
        else $error("Read issued while channel 0 almost-full was high");

endmodule

/* include/mpf_settings.svh */
// Memory request subsystem settings
`ifndef MPF_SETTINGS_SVH
`define MPF_SETTINGS_SVH

// Width of one data word in bits
`define MPF_DATA_WIDTH 64

// Word address width, so the memory holds 64 words
`define MPF_ADDR_WIDTH 6

// Width of the request metadata tag
`define MPF_MDATA_WIDTH 8

// Read scoreboard size and the free slots it keeps back for in-flight reads
`define MPF_SB_ENTRIES 8
`define MPF_SB_RESERVE 2

// Pending read stack in the platform stub and its almost-full reserve
`define MPF_STACK_DEPTH 8
`define MPF_STACK_RESERVE 2

`endif

/* testbench/mpfReadTop_tb.sv */
// Sorted read subsystem testbench
`timescale 1ns/1ps
`include "mpf_settings.svh"

module mpfReadTop_tb
    import mpf_pkg::*;
();

    localparam logic [1:0] KindIdle  = 2'd0;
    localparam logic [1:0] KindWrite = 2'd1;
    localparam logic [1:0] KindRead  = 2'd2;

    // Scoreboard occupancy at which almost-full must already be up
    localparam int SbLimit = `MPF_SB_ENTRIES - `MPF_SB_RESERVE;

    // A table row whose data field is ignored when the row asks for random data
    typedef struct packed {
        logic [1:0] kind;
        logic       randData;
        addr_t      addr;
        mdata_t     tag;
        data_t      data;
    } row_t;

    // Expected read response and expected write ack
    typedef struct packed {
        mdata_t tag;
        data_t  data;
    } expRd_t;

    typedef struct packed {
        logic [31:0] cycle;
        mdata_t      tag;
    } expAck_t;

    logic   clk;
    logic   rst;
    c0Req_t c0Req;
    c1Req_t c1Req;
    c0Rsp_t c0Rsp;
    logic   c0AlmFull;
    logic   c1AlmFull;

    row_t    rows [$];
    string   rowName [$];
    expRd_t  expRdQ [$];
    string   rdName [$];
    expAck_t ackQ [$];
    string   ackName [$];
    data_t   refMem [2 ** `MPF_ADDR_WIDTH];

    int   seed;
    int   cycleCount;
    int   outstanding;
    logic tableReady;
    logic expWr;

    mpfReadTop i_mpfReadTop (
        .clk       (clk),
        .rst       (rst),
        .c0Req     (c0Req),
        .c1Req     (c1Req),
        .c0Rsp     (c0Rsp),
        .c0AlmFull (c0AlmFull),
        .c1AlmFull (c1AlmFull)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) cycleCount <= cycleCount + 1;

    // ================================================
    // Failure reporting
    // ================================================

    task automatic failRun(input string msg);
        $display("ERROR: %s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic checkValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        if (expected !== actual)
        begin
            $display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
            failRun("Value mismatch");
        end
    endtask

    // ================================================
    // Stimulus table
    // ================================================

    task automatic addRow(input logic [1:0] kind, input int addr, input logic randData,
                          input logic [63:0] data, input int tag, input string name);
        row_t r;
        r.kind     = kind;
        r.randData = randData;
        r.addr     = addr_t'(addr);
        r.tag      = mdata_t'(tag);
        r.data     = data;
        rows.push_back(r);
        rowName.push_back(name);
    endtask

    task automatic buildTable();
        int i;
        // Fill the low words with random data in every other word
        for (i = 0; i < 16; i++)
        begin
            addRow(KindWrite, i, (i % 2) == 0, 64'hC0DE_0000_0000_0000 | 64'(i),
                   8'hA0 + i, "writes");
        end
        for (i = 0; i < 4; i++) addRow(KindIdle, 0, 1'b0, '0, 0, "idle");
        // Two back-to-back bursts of eight, which the stub returns reversed
        for (i = 0; i < 16; i++) addRow(KindRead, i, 1'b0, '0, 8'h10 + i, "burst reads");
        for (i = 0; i < 4; i++) addRow(KindIdle, 0, 1'b0, '0, 0, "idle");
        // Writes to the upper words woven between reads of the lower ones
        for (i = 0; i < 8; i++)
        begin
            addRow(KindWrite, 32 + i, 1'b1, '0, 8'hB0 + i, "mixed");
            addRow(KindRead, i, 1'b0, '0, 8'h30 + i, "mixed");
        end
        for (i = 0; i < 8; i++) addRow(KindRead, 32 + i, 1'b0, '0, 8'h40 + i, "readback");
        // Let every read drain so the overwrite cannot race a pending read
        for (i = 0; i < 24; i++) addRow(KindIdle, 0, 1'b0, '0, 0, "idle");
        addRow(KindWrite, 3, 1'b1, '0, 8'hC3, "overwrite");
        addRow(KindRead, 3, 1'b0, '0, 8'h53, "overwrite");
        addRow(KindRead, 35, 1'b0, '0, 8'h54, "overwrite");
    endtask

    // ================================================
    // Response monitor
    // ================================================

    // Sampled mid-cycle, where all DUT outputs have settled
    always @(negedge clk)
    begin
        if (!rst)
        begin
            checkValue("channel sync", 64'(c0AlmFull), 64'(c1AlmFull));
            if (outstanding >= SbLimit && !c0AlmFull)
            begin
                failRun("Scoreboard near full but channel 0 almost-full is low");
            end

            // Write acks come at a fixed cycle, so the strobe is checked every cycle
            expWr = ackQ.size() > 0 && ackQ[0].cycle == 32'(cycleCount);
            checkValue("write ack strobe", 64'(expWr), 64'(c0Rsp.wrValid));
            if (expWr)
            begin
                checkValue({ackName[0], " ack tag"}, 64'(ackQ[0].tag), 64'(c0Rsp.mdata));
                void'(ackQ.pop_front());
                void'(ackName.pop_front());
            end

            if (c0Rsp.rdValid)
            begin
                if (expRdQ.size() == 0)
                begin
                    failRun("Read response arrived with no read outstanding");
                end
                else
                begin
                    checkValue({rdName[0], " tag"}, 64'(expRdQ[0].tag), 64'(c0Rsp.mdata));
                    checkValue({rdName[0], " data"}, expRdQ[0].data, c0Rsp.data);
                    void'(expRdQ.pop_front());
                    void'(rdName.pop_front());
                end
            end

            // Track slots as the scoreboard sees them at the coming edge
            if (c0Req.rdValid) outstanding++;
            if (c0Rsp.rdValid) outstanding--;
        end
    end

    // Limit grows with the table so longer tables get more time
    initial
    begin
        wait (tableReady);
        repeat (rows.size() * 40 + 200) @(posedge clk);
        failRun("Watchdog timeout, the run did not finish in time");
    end

    // ================================================
    // Main sequence
    // ================================================

    initial
    begin
        row_t  r;
        data_t wrData;
        int    i;
        int    drainCount;
        c0Req       = '0;
        c1Req       = '0;
        rst         = 1'b1;
        seed        = 85218;
        cycleCount  = 0;
        outstanding = 0;
        tableReady  = 1'b0;
        buildTable();
        tableReady = 1'b1;

        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        checkValue("reset rdValid", 64'(0), 64'(c0Rsp.rdValid));
        checkValue("reset wrValid", 64'(0), 64'(c0Rsp.wrValid));
        checkValue("reset c0AlmFull", 64'(0), 64'(c0AlmFull));
        checkValue("reset c1AlmFull", 64'(0), 64'(c1AlmFull));

        for (i = 0; i < rows.size(); i++)
        begin
            @(posedge clk);
            #1;
            c0Req = '0;
            c1Req = '0;
            r = rows[i];
            // Almost-full is registered state, so it is stable once the edge is past
            while (r.kind != KindIdle && ((r.kind == KindRead) ? c0AlmFull : c1AlmFull))
            begin
                @(posedge clk);
                #1;
            end
            if (r.kind == KindWrite)
            begin
                wrData = r.randData ? {$random(seed), $random(seed)} : r.data;
                refMem[r.addr] = wrData;
                c1Req = c1Req_t'{wrValid: 1'b1, addr: r.addr, mdata: r.tag, data: wrData};
                ackQ.push_back(expAck_t'{cycle: 32'(cycleCount + 2), tag: r.tag});
                ackName.push_back(rowName[i]);
            end
            else if (r.kind == KindRead)
            begin
                c0Req = c0Req_t'{rdValid: 1'b1, addr: r.addr, mdata: r.tag};
                expRdQ.push_back(expRd_t'{tag: r.tag, data: refMem[r.addr]});
                rdName.push_back(rowName[i]);
            end
        end
        @(posedge clk);
        #1;
        c0Req = '0;
        c1Req = '0;

        drainCount = 0;
        while ((expRdQ.size() != 0 || ackQ.size() != 0) && drainCount < 200)
        begin
            @(posedge clk);
            drainCount++;
        end
        repeat (2) @(posedge clk);
        if (expRdQ.size() == 0 && ackQ.size() == 0 && outstanding == 0)
        begin
            $display("ALL TESTS PASSED");
            $finish;
        end
        else
        begin
            failRun("Responses still outstanding at the end of the run");
        end
    end

endmodule
